/* include/cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// cpu address split: tag | index | offset
`define ADDR_BITS   10
`define OFFSET_BITS 4
`define INDEX_BITS  2
`define TAG_BITS    4

// one cache line, also one memory word
`define LINE_BYTES  16
`define LINE_BITS   (`LINE_BYTES * 8)

// 1 KB of backing store in line units
`define MEM_LINES   64

// memory latency per handshake phase, in cycles
`define MEM_WAIT    2

`endif

/* source/cache_pkg.sv */
`include "cache_defines.svh"

package cache_pkg;

    // one-cycle request strobe from the cpu
    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [`ADDR_BITS-1:0] addr;
        logic [7:0]            wdata;
    } cpu_req_t;

    // one-cycle response strobe back to the cpu
    typedef struct packed {
        logic       valid;
        logic       hit;
        logic [7:0] rdata;
    } cpu_rsp_t;

    // per-line bookkeeping
    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [`TAG_BITS-1:0] tag;
    } line_meta_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        ALLOCATE,
        RESPOND
    } cache_state_t;

endpackage

/* source/bus_pkg.sv */
`include "cache_defines.svh"

package bus_pkg;

    // master side of all five channels, addr is a line address
    typedef struct packed {
        logic                               aw_valid;
        logic                               w_valid;
        logic                               b_ready;
        logic                               ar_valid;
        logic                               r_ready;
        logic [`TAG_BITS+`INDEX_BITS-1:0]   addr;
        logic [`LINE_BITS-1:0]              wdata;
    } bus_req_t;

    // slave side
    typedef struct packed {
        logic                  aw_ready;
        logic                  w_ready;
        logic                  b_valid;
        logic                  ar_ready;
        logic                  r_valid;
        logic [`LINE_BITS-1:0] rdata;
    } bus_rsp_t;

    typedef enum logic [2:0] {
        IDLE  = 3'b000,
        WADDR = 3'b001,
        WDATA = 3'b010,
        BRESP = 3'b011,
        RADDR = 3'b100,
        RDATA = 3'b101
    } bus_state_t;

endpackage

/* source/cache_controller.sv */
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_controller import cache_pkg::*; (
    input  logic                             clk,
    input  logic                             reset,
    input  cpu_req_t                         cpu_req,
    input  line_meta_t                       meta,
    input  logic [`LINE_BITS-1:0]            line_rdata,
    input  logic                             done,
    input  logic [`LINE_BITS-1:0]            bus_rdata,
    output cpu_rsp_t                         cpu_rsp,
    output logic [`INDEX_BITS-1:0]           index,
    output logic                             fill,
    output logic [`TAG_BITS-1:0]             fill_tag,
    output logic [`LINE_BITS-1:0]            fill_data,
    output logic                             byte_write,
    output logic [`OFFSET_BITS-1:0]          byte_offset,
    output logic [7:0]                       byte_wdata,
    output logic                             start_write,
    output logic                             start_read,
    output logic [`TAG_BITS+`INDEX_BITS-1:0] bus_addr,
    output logic [`LINE_BITS-1:0]            bus_wdata
);

    cache_state_t state, next_state;
    cpu_req_t req_q;
    logic [7:0] rdata_q;
    logic missed;
    logic refill_start;
    logic hit;
    logic victim;
    logic [`TAG_BITS-1:0] req_tag;
    logic [`INDEX_BITS-1:0] req_index;
    logic [`OFFSET_BITS-1:0] req_offset;

    assign req_tag    = req_q.addr[`ADDR_BITS-1 -: `TAG_BITS];
    assign req_index  = req_q.addr[`OFFSET_BITS +: `INDEX_BITS];
    assign req_offset = req_q.addr[`OFFSET_BITS-1:0];

    assign hit    = meta.valid && (meta.tag == req_tag);
    assign victim = meta.valid && meta.dirty;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state        <= IDLE;
            missed       <= 1'b0;
            refill_start <= 1'b0;
        end else begin
            state <= next_state;
            // bus_master is back in IDLE the cycle after the writeback done
            refill_start <= (state == WRITEBACK) && done;
            if (state == IDLE && cpu_req.valid) begin
                missed <= 1'b0;
            end else if (state == LOOKUP && !hit) begin
                missed <= 1'b1;
            end
        end
    end

    // request and read byte only change while idle or on a hit
    always_ff @(posedge clk) begin
        if (state == IDLE && cpu_req.valid) begin
            req_q <= cpu_req;
        end
        if (state == LOOKUP && hit) begin
            rdata_q <= req_q.write ? req_q.wdata : line_rdata[req_offset*8 +: 8];
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:      if (cpu_req.valid) next_state = LOOKUP;
            LOOKUP: begin
                if (hit) begin
                    next_state = RESPOND;
                end else if (victim) begin
                    next_state = WRITEBACK;
                end else begin
                    next_state = ALLOCATE;
                end
            end
            WRITEBACK: if (done) next_state = ALLOCATE;
            ALLOCATE:  if (done) next_state = LOOKUP;
            RESPOND:   next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    // bus_master latches addr and line on the strobe
    assign start_write = (state == LOOKUP) && !hit && victim;
    assign start_read  = ((state == LOOKUP) && !hit && !victim) || refill_start;
    assign bus_addr    = start_write ? {meta.tag, req_index} : {req_tag, req_index};
    assign bus_wdata   = line_rdata;

    assign index       = req_index;
    assign fill        = (state == ALLOCATE) && done;
    assign fill_tag    = req_tag;
    assign fill_data   = bus_rdata;
    assign byte_write  = (state == LOOKUP) && hit && req_q.write;
    assign byte_offset = req_offset;
    assign byte_wdata  = req_q.wdata;

    assign cpu_rsp.valid = (state == RESPOND);
    assign cpu_rsp.hit   = !missed;
    assign cpu_rsp.rdata = rdata_q;

endmodule

/* source/cache_array.sv */
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_array import cache_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`INDEX_BITS-1:0]  index,
    input  logic                    fill,
    input  logic [`TAG_BITS-1:0]    fill_tag,
    input  logic [`LINE_BITS-1:0]   fill_data,
    input  logic                    byte_write,
    input  logic [`OFFSET_BITS-1:0] byte_offset,
    input  logic [7:0]              byte_wdata,
    output line_meta_t              meta,
    output logic [`LINE_BITS-1:0]   line_rdata
);

    line_meta_t            meta_q [1 << `INDEX_BITS];
    logic [`LINE_BITS-1:0] data_q [1 << `INDEX_BITS];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < (1 << `INDEX_BITS); i++) begin
                meta_q[i] <= '0;
                data_q[i] <= '0;
            end
        end else if (fill) begin
            // refill leaves a clean line
            meta_q[index].valid <= 1'b1;
            meta_q[index].dirty <= 1'b0;
            meta_q[index].tag   <= fill_tag;
            data_q[index]       <= fill_data;
        end else if (byte_write) begin
            meta_q[index].dirty <= 1'b1;
            // one byte lane only
            for (int b = 0; b < `LINE_BYTES; b++) begin
                if (b == byte_offset) begin
                    data_q[index][b*8 +: 8] <= byte_wdata;
                end
            end
        end
    end

    // combinational lookup by index
    assign meta       = meta_q[index];
    assign line_rdata = data_q[index];

endmodule

/* source/bus_master.sv */
`timescale 1ns/1ps
`include "cache_defines.svh"

module bus_master import bus_pkg::*; (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start_write,
    input  logic                             start_read,
    input  logic [`TAG_BITS+`INDEX_BITS-1:0] addr,
    input  logic [`LINE_BITS-1:0]            wdata,
    input  bus_rsp_t                         bus_rsp,
    output bus_req_t                         bus_req,
    output logic                             done,
    output logic [`LINE_BITS-1:0]            rdata
);

    bus_state_t state, next_state;
    logic [`TAG_BITS+`INDEX_BITS-1:0] addr_q;
    logic [`LINE_BITS-1:0] wdata_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // held for the whole transfer
    always_ff @(posedge clk) begin
        if (state == IDLE && (start_write || start_read)) begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start_write) begin
                    next_state = WADDR;
                end else if (start_read) begin
                    next_state = RADDR;
                end
            end
            WADDR:   if (bus_rsp.aw_ready) next_state = WDATA;
            WDATA:   if (bus_rsp.w_ready) next_state = BRESP;
            BRESP:   if (bus_rsp.b_valid) next_state = IDLE;
            RADDR:   if (bus_rsp.ar_ready) next_state = RDATA;
            RDATA:   if (bus_rsp.r_valid) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // valids and readies follow the state, held until the handshake
    assign bus_req.aw_valid = (state == WADDR);
    assign bus_req.w_valid  = (state == WDATA);
    assign bus_req.b_ready  = (state == BRESP);
    assign bus_req.ar_valid = (state == RADDR);
    assign bus_req.r_ready  = (state == RDATA);
    assign bus_req.addr     = addr_q;
    assign bus_req.wdata    = wdata_q;

    assign done  = ((state == BRESP) && bus_rsp.b_valid) || ((state == RDATA) && bus_rsp.r_valid);
    assign rdata = bus_rsp.rdata;

endmodule

/* source/main_memory.sv */
`timescale 1ns/1ps
`include "cache_defines.svh"

module main_memory import bus_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  bus_req_t bus_req,
    output bus_rsp_t bus_rsp
);

    logic [`LINE_BITS-1:0] mem [`MEM_LINES];
    logic [`TAG_BITS+`INDEX_BITS-1:0] waddr_q, raddr_q;
    logic [$clog2(`MEM_WAIT+1)-1:0] wait_cnt;
    logic b_pend, r_pend;
    logic waited, active;
    logic aw_hs, w_hs, b_hs, ar_hs, r_hs;

    assign aw_hs = bus_req.aw_valid && bus_rsp.aw_ready;
    assign w_hs  = bus_req.w_valid && bus_rsp.w_ready;
    assign b_hs  = bus_rsp.b_valid && bus_req.b_ready;
    assign ar_hs = bus_req.ar_valid && bus_rsp.ar_ready;
    assign r_hs  = bus_rsp.r_valid && bus_req.r_ready;

    // one phase is open at a time, so one counter serves all
    assign active = bus_req.aw_valid || bus_req.w_valid || bus_req.ar_valid || b_pend || r_pend;
    assign waited = (wait_cnt == `MEM_WAIT);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wait_cnt <= '0;
            b_pend   <= 1'b0;
            r_pend   <= 1'b0;
        end else begin
            if (aw_hs || w_hs || b_hs || ar_hs || r_hs) begin
                wait_cnt <= '0;
            end else if (active && !waited) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
            if (w_hs) b_pend <= 1'b1;
            else if (b_hs) b_pend <= 1'b0;
            if (ar_hs) r_pend <= 1'b1;
            else if (r_hs) r_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) waddr_q <= bus_req.addr;
        if (ar_hs) raddr_q <= bus_req.addr;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `MEM_LINES; i++) begin
                mem[i] <= '0;
            end
        end else if (w_hs) begin
            mem[waddr_q] <= bus_req.wdata;
        end
    end

    assign bus_rsp.aw_ready = bus_req.aw_valid && waited;
    assign bus_rsp.w_ready  = bus_req.w_valid && waited;
    assign bus_rsp.b_valid  = b_pend && waited;
    assign bus_rsp.ar_ready = bus_req.ar_valid && waited;
    assign bus_rsp.r_valid  = r_pend && waited;
    assign bus_rsp.rdata    = mem[raddr_q];

endmodule

/* source/cache_system.sv */
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_system import cache_pkg::*, bus_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  cpu_req_t cpu_req,
    output cpu_rsp_t cpu_rsp
);

    line_meta_t meta;
    logic [`LINE_BITS-1:0] line_rdata;
    logic [`INDEX_BITS-1:0] index;
    logic fill;
    logic [`TAG_BITS-1:0] fill_tag;
    logic [`LINE_BITS-1:0] fill_data;
    logic byte_write;
    logic [`OFFSET_BITS-1:0] byte_offset;
    logic [7:0] byte_wdata;

    // controller to bus sequencer
    logic start_write, start_read, done;
    logic [`TAG_BITS+`INDEX_BITS-1:0] bus_addr;
    logic [`LINE_BITS-1:0] bus_wdata, bus_rdata;

    bus_req_t bus_req;
    bus_rsp_t bus_rsp;

    cache_controller u_cache_controller (
        .clk         (clk),
        .reset       (reset),
        .cpu_req     (cpu_req),
        .meta        (meta),
        .line_rdata  (line_rdata),
        .done        (done),
        .bus_rdata   (bus_rdata),
        .cpu_rsp     (cpu_rsp),
        .index       (index),
        .fill        (fill),
        .fill_tag    (fill_tag),
        .fill_data   (fill_data),
        .byte_write  (byte_write),
        .byte_offset (byte_offset),
        .byte_wdata  (byte_wdata),
        .start_write (start_write),
        .start_read  (start_read),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata)
    );

    cache_array u_cache_array (
        .clk         (clk),
        .reset       (reset),
        .index       (index),
        .fill        (fill),
        .fill_tag    (fill_tag),
        .fill_data   (fill_data),
        .byte_write  (byte_write),
        .byte_offset (byte_offset),
        .byte_wdata  (byte_wdata),
        .meta        (meta),
        .line_rdata  (line_rdata)
    );

    bus_master u_bus_master (
        .clk         (clk),
        .reset       (reset),
        .start_write (start_write),
        .start_read  (start_read),
        .addr        (bus_addr),
        .wdata       (bus_wdata),
        .bus_rsp     (bus_rsp),
        .bus_req     (bus_req),
        .done        (done),
        .rdata       (bus_rdata)
    );

    main_memory u_main_memory (
        .clk     (clk),
        .reset   (reset),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

endmodule

/* test/cache_checker.sv */
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_checker import cache_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  cpu_req_t cpu_req,
    input  cpu_rsp_t cpu_rsp,
    input  cpu_rsp_t table_rsp,
    output int       tests_done,
    output int       errors
);

    logic [7:0]           model_mem [1 << `ADDR_BITS];
    logic                 model_valid [1 << `INDEX_BITS];
    logic [`TAG_BITS-1:0] model_tag [1 << `INDEX_BITS];
    cpu_req_t             req_q [$];
    cpu_rsp_t             model_q [$];
    cpu_rsp_t             table_q [$];
    int                   issue_q [$];
    int                   cycle;

    initial begin
        tests_done = 0;
        errors     = 0;
        cycle      = 0;
        foreach (model_mem[i]) begin
            model_mem[i] = 8'h00;
        end
        foreach (model_valid[i]) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
    end

    task automatic take_request();
        logic [`INDEX_BITS-1:0] idx;
        logic [`TAG_BITS-1:0]   tag;
        cpu_rsp_t               predicted;
        idx = cpu_req.addr[`OFFSET_BITS +: `INDEX_BITS];
        tag = cpu_req.addr[`ADDR_BITS-1 -: `TAG_BITS];
        predicted.valid = 1'b1;
        predicted.hit   = model_valid[idx] && (model_tag[idx] == tag);
        predicted.rdata = cpu_req.write ? cpu_req.wdata : model_mem[cpu_req.addr];
        // write-allocate, so every access leaves its line resident
        model_valid[idx] = 1'b1;
        model_tag[idx]   = tag;
        if (cpu_req.write) begin
            model_mem[cpu_req.addr] = cpu_req.wdata;
        end
        req_q.push_back(cpu_req);
        model_q.push_back(predicted);
        table_q.push_back(table_rsp);
        issue_q.push_back(cycle);
    endtask

    task automatic check_response();
        cpu_req_t req;
        cpu_rsp_t exp;
        cpu_rsp_t tbl;
        int       latency;
        int       fails;
        if (model_q.size() == 0) begin
            $display("a response came at %0t with no request outstanding", $time);
            errors++;
            return;
        end
        req     = req_q.pop_front();
        exp     = model_q.pop_front();
        tbl     = table_q.pop_front();
        latency = cycle - issue_q.pop_front();
        fails   = 0;
        if (cpu_rsp.hit !== exp.hit) begin
            $display("error at %0t: test %0d hit %b, model expects %b",
                     $time, tests_done + 1, cpu_rsp.hit, exp.hit);
            fails++;
        end
        if (cpu_rsp.rdata !== exp.rdata) begin
            $display("error at %0t: test %0d rdata %h, model expects %h",
                     $time, tests_done + 1, cpu_rsp.rdata, exp.rdata);
            fails++;
        end
        if (tbl.valid && (cpu_rsp.hit !== tbl.hit || cpu_rsp.rdata !== tbl.rdata)) begin
            $display("error at %0t: test %0d hit %b rdata %h, table expects hit %b rdata %h",
                     $time, tests_done + 1, cpu_rsp.hit, cpu_rsp.rdata, tbl.hit, tbl.rdata);
            fails++;
        end
        // hits answer two cycles after the strobe
        if (exp.hit && latency != 2) begin
            $display("error at %0t: test %0d hit answered after %0d cycles, expected 2",
                     $time, tests_done + 1, latency);
            fails++;
        end
        tests_done++;
        errors = errors + fails;
        $display("test %0d %s addr %h hit %b rdata %h %s", tests_done,
                 req.write ? "write" : "read ", req.addr, cpu_rsp.hit, cpu_rsp.rdata,
                 (fails == 0) ? "ok" : "mismatch");
    endtask

    always @(posedge clk) begin
        if (reset) begin
            cycle++;
            if (cpu_rsp.valid) begin
                check_response();
            end
            if (cpu_req.valid) begin
                take_request();
            end
        end
    end

endmodule

/* test/tb_cache_system.sv */
`timescale 1ns/1ps
`include "cache_defines.svh"

module tb_cache_system import cache_pkg::*; ();

    typedef struct packed {
        logic                  write;
        logic [`ADDR_BITS-1:0] addr;
        logic [7:0]            wdata;
        logic                  hit;
        logic [7:0]            rdata;
    } vector_t;

    localparam int num_table   = 18;
    localparam int num_random  = 40;
    localparam int num_entries = num_table + num_random;

    // write, addr, wdata, expected hit, expected rdata
    localparam vector_t table_vec [num_table] = '{
        {1'b0, 10'h000, 8'h00, 1'b0, 8'h00},
        {1'b0, 10'h3a7, 8'h00, 1'b0, 8'h00},
        {1'b1, 10'h012, 8'ha5, 1'b0, 8'ha5},
        {1'b0, 10'h012, 8'h00, 1'b1, 8'ha5},
        {1'b1, 10'h013, 8'h3c, 1'b1, 8'h3c},
        {1'b1, 10'h01f, 8'h77, 1'b1, 8'h77},
        {1'b0, 10'h011, 8'h00, 1'b1, 8'h00},
        {1'b0, 10'h013, 8'h00, 1'b1, 8'h3c},
        {1'b0, 10'h014, 8'h00, 1'b1, 8'h00},
        {1'b0, 10'h01f, 8'h00, 1'b1, 8'h77},
        // same index, other tag: dirty line goes back to memory
        {1'b0, 10'h052, 8'h00, 1'b0, 8'h00},
        {1'b0, 10'h012, 8'h00, 1'b0, 8'ha5},
        {1'b0, 10'h013, 8'h00, 1'b1, 8'h3c},
        {1'b0, 10'h01f, 8'h00, 1'b1, 8'h77},
        {1'b1, 10'h0c5, 8'h19, 1'b0, 8'h19},
        {1'b0, 10'h005, 8'h00, 1'b0, 8'h00},
        {1'b0, 10'h0c5, 8'h00, 1'b0, 8'h19},
        {1'b0, 10'h3a7, 8'h00, 1'b1, 8'h00}
    };

    logic     clk;
    logic     reset;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    cpu_rsp_t table_rsp;
    int       tests_done;
    int       errors;

    cache_system u_cache_system (
        .clk     (clk),
        .reset   (reset),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp)
    );

    cache_checker u_cache_checker (
        .clk        (clk),
        .reset      (reset),
        .cpu_req    (cpu_req),
        .cpu_rsp    (cpu_rsp),
        .table_rsp  (table_rsp),
        .tests_done (tests_done),
        .errors     (errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic send_request(input logic write, input logic [`ADDR_BITS-1:0] addr,
                                input logic [7:0] wdata, input cpu_rsp_t expect_rsp);
        cpu_req.valid <= 1'b1;
        cpu_req.write <= write;
        cpu_req.addr  <= addr;
        cpu_req.wdata <= wdata;
        table_rsp     <= expect_rsp;
        @(posedge clk);
        cpu_req.valid   <= 1'b0;
        table_rsp.valid <= 1'b0;
        do begin
            @(posedge clk);
        end while (!cpu_rsp.valid);
    endtask

    initial begin
        logic [31:0] rnd;
        cpu_rsp_t    no_table;
        reset     = 1'b0;
        cpu_req   = '0;
        table_rsp = '0;
        no_table  = '0;
        rnd       = 32'hd6d48375;
        repeat (8) @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);
        foreach (table_vec[i]) begin
            send_request(table_vec[i].write, table_vec[i].addr, table_vec[i].wdata,
                         {1'b1, table_vec[i].hit, table_vec[i].rdata});
        end
        // tags 0 to 3 only, so hits and evictions both show up
        for (int i = 0; i < num_random; i++) begin
            rnd = xorshift(rnd);
            send_request(rnd[0], {2'b00, rnd[15:8]}, rnd[23:16], no_table);
        end
        repeat (4) @(posedge clk);
        $display("%0d tests run, %0d errors", tests_done, errors);
        if (errors == 0 && tests_done == num_entries) begin
            $display("All tests passed!");
        end else begin
            if (tests_done != num_entries) begin
                $display("only %0d of %0d requests got a response", tests_done, num_entries);
            end
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        repeat (num_entries * 40) @(posedge clk);
        $display("timeout: the cache stopped answering after %0d tests", tests_done);
        $display("Test failures found");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
source/cache_pkg.sv
source/bus_pkg.sv
source/cache_controller.sv
source/cache_array.sv
source/bus_master.sv
source/main_memory.sv
source/cache_system.sv
test/cache_checker.sv
test/tb_cache_system.sv

/* Bender.yml */
package:
  name: cache_system

export_include_dirs:
  - include

sources:
  - source/cache_pkg.sv
  - source/bus_pkg.sv
  - source/cache_controller.sv
  - source/cache_array.sv
  - source/bus_master.sv
  - source/main_memory.sv
  - source/cache_system.sv
  - target: test
    files:
      - test/cache_checker.sv
      - test/tb_cache_system.sv
